/* list.f */
+incdir+logic
logic/scurve_pkg.sv
logic/scurve_sequencer.sv
logic/trigger_counter.sv
logic/result_packer.sv
logic/scurve_test_top.sv
testbench/asic_model.sv
testbench/scurve_test_top_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the S-curve scan testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f list.f \
  --top-module scurve_test_top_tb \
  -o scurve_sim

./obj_dir/scurve_sim > sim.log 2>&1
cat sim.log

if grep -q "Test FAILED" sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi
if ! grep -q "Test OK" sim.log; then
  echo "simulation ended without a result, see sim.log"
  exit 1
fi
echo "simulation passed"

/* testbench/scurve_test_top_tb.sv */
`default_nettype none

`include "scurve_consts.svh"

module scurve_test_top_tb
  import scurve_pkg::*;
();

  logic                             clk_n;
  logic                             reset_n;
  scurve_cfg_t                      cfg;
  logic                             start;
  logic                             scan_done;
  logic                             fifo_wr_en;
  logic [`WORD_W-1:0]               fifo_din;
  logic                             fifo_full = 1'b0;
  logic [`NUM_CHN-1:0]              ctest_mask;
  logic [`DAC_W-1:0]                dac_code;
  logic                             sc_param_load;
  logic                             config_done;
  logic                             clk_ext;
  logic                             trigger0_b;
  logic                             trigger1_b;
  logic                             trigger2_b;
  logic [`NUM_TRIG-1:0][`DAC_W-1:0] threshold;

  logic [31:0]        lfsr = 32'hfb5d_7616;
  logic               bp_on = 1'b0;
  logic               load_q = 1'b0;
  logic [`NUM_CHN-1:0] exp_mask;
  scurve_word_u       got_q[$];
  scurve_word_u       exp_q[$];
  int                 load_cnt;
  int                 done_cnt;
  int                 mask_errs;
  int                 full_writes;
  int                 tests_run;
  int                 tests_passed;
  int                 tests_failed;

  scurve_test_top scurve_test_top_inst (
    .clk_n         (clk_n),
    .reset_n       (reset_n),
    .cfg           (cfg),
    .start         (start),
    .scan_done     (scan_done),
    .fifo_wr_en    (fifo_wr_en),
    .fifo_din      (fifo_din),
    .fifo_full     (fifo_full),
    .ctest_mask    (ctest_mask),
    .dac_code      (dac_code),
    .sc_param_load (sc_param_load),
    .config_done   (config_done),
    .clk_ext       (clk_ext),
    .trigger0_b    (trigger0_b),
    .trigger1_b    (trigger1_b),
    .trigger2_b    (trigger2_b)
  );

  asic_model asic_model_inst (
    .clk_n         (clk_n),
    .reset_n       (reset_n),
    .sc_param_load (sc_param_load),
    .dac_code      (dac_code),
    .threshold     (threshold),
    .config_done   (config_done),
    .clk_ext       (clk_ext),
    .trigger0_b    (trigger0_b),
    .trigger1_b    (trigger1_b),
    .trigger2_b    (trigger2_b)
  );

  initial begin
    clk_n = 1'b0;
    forever #50 clk_n = ~clk_n;
  end

  // Galois form with taps 32 30 26 25
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      lfsr_next = (s >> 1) ^ 32'ha300_0000;
    end else begin
      lfsr_next = s >> 1;
    end
  endfunction

  // FIFO full stimulus takes one LFSR bit per cycle
  always @(negedge clk_n) begin
    if (bp_on) begin
      lfsr = lfsr_next(lfsr);
      fifo_full <= lfsr[0];
    end else begin
      fifo_full <= 1'b0;
    end
  end

  // FIFO sink and slow-control monitor
  always @(posedge clk_n) begin
    if (reset_n) begin
      if (fifo_wr_en) begin
        got_q.push_back(fifo_din);
        if (fifo_full) begin
          full_writes++;
          $display("at time %0t the packer wrote a word while the FIFO was full", $time);
        end
      end
      if (sc_param_load && !load_q) begin
        load_cnt++;
      end
      if (sc_param_load && ctest_mask !== exp_mask) begin
        mask_errs++;
        $display("mismatch at time %0t: ctest_mask got %h expected %h",
                 $time, ctest_mask, exp_mask);
      end
      if (scan_done) begin
        done_cnt++;
      end
    end
    load_q = sc_param_load;
  end

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp_v, inout int errs);
    if (got !== exp_v) begin
      errs++;
      $display("mismatch at time %0t: %s got %0h expected %0h", $time, name, got, exp_v);
    end
  endtask

  task automatic report_test(input string name, input int errs);
    tests_run++;
    if (errs == 0) begin
      tests_passed++;
      $display("%s: pass", name);
    end else begin
      tests_failed++;
      $display("%s: fail with %0d errors", name, errs);
    end
  endtask

  task automatic reset_dut();
    @(negedge clk_n);
    reset_n = 1'b0;
    start   = 1'b0;
    bp_on   = 1'b0;
    repeat (3) @(negedge clk_n);
    got_q.delete();
    load_cnt    = 0;
    done_cnt    = 0;
    mask_errs   = 0;
    full_writes = 0;
    reset_n     = 1'b1;
  endtask

  // Header word and one count per trigger for each step
  // A trigger counts the full window at or above its threshold
  task automatic build_expected(input scurve_cfg_t c);
    scurve_word_u w;
    int           first;
    int           last;
    exp_q.delete();
    first = c.all_chn ? 0 : int'(c.single_chn);
    last  = c.all_chn ? `NUM_CHN - 1 : int'(c.single_chn);
    for (int ch = first; ch <= last; ch++) begin
      for (int code = c.dac_start; code <= c.dac_stop; code++) begin
        w              = '0;
        w.hdr.channel  = `CHN_W'(ch);
        w.hdr.dac_code = `DAC_W'(code);
        exp_q.push_back(w);
        for (int k = 0; k < `NUM_TRIG; k++) begin
          w.cnt.count = (code >= threshold[k]) ? c.cpt_max : '0;
          exp_q.push_back(w);
        end
      end
    end
  endtask

  task automatic compare_stream(inout int errs);
    scurve_word_u got_w;
    scurve_word_u exp_w;
    check_value("FIFO word count", got_q.size(), exp_q.size(), errs);
    for (int i = 0; i < got_q.size() && i < exp_q.size(); i++) begin
      got_w = got_q[i];
      exp_w = exp_q[i];
      if (i % 4 == 0) begin
        check_value($sformatf("word %0d hdr.channel", i),
                    got_w.hdr.channel, exp_w.hdr.channel, errs);
        check_value($sformatf("word %0d hdr.dac_code", i),
                    got_w.hdr.dac_code, exp_w.hdr.dac_code, errs);
      end else begin
        check_value($sformatf("word %0d cnt.count", i),
                    got_w.cnt.count, exp_w.cnt.count, errs);
      end
    end
  endtask

  task automatic run_scan(input scurve_cfg_t c, input int limit, output bit ok);
    int n;
    ok = 1'b0;
    n  = 0;
    @(negedge clk_n);
    cfg   = c;
    start = 1'b1;
    @(negedge clk_n);
    start = 1'b0;
    while (!ok && n < limit) begin
      @(negedge clk_n);
      n++;
      if (done_cnt != 0) begin
        ok = 1'b1;
      end
    end
    if (!ok) begin
      $display("timeout: scan_done did not rise within %0d cycles", limit);
    end
    // Let any stray write or second done pulse show up
    repeat (40) @(negedge clk_n);
  endtask

  task automatic scan_and_check(input scurve_cfg_t c, input logic [63:0] mask,
                                input bit bp, inout int errs);
    bit ok;
    reset_dut();
    exp_mask = mask;
    bp_on    = bp;
    build_expected(c);
    run_scan(c, 30000, ok);
    bp_on = 1'b0;
    if (!ok) begin
      errs++;
    end
    compare_stream(errs);
    check_value("config loads", load_cnt, exp_q.size() / 4, errs);
    check_value("scan_done pulses", done_cnt, 1, errs);
    errs += mask_errs + full_writes;
  endtask

  task automatic idle_after_reset();
    int errs;
    errs = 0;
    reset_dut();
    for (int n = 0; n < 20; n++) begin
      @(negedge clk_n);
      check_value("sc_param_load", sc_param_load, 0, errs);
      check_value("fifo_wr_en", fifo_wr_en, 0, errs);
      check_value("scan_done", scan_done, 0, errs);
      check_value("ctest_mask", ctest_mask, 0, errs);
      check_value("dac_code", dac_code, 0, errs);
      check_value("count_ack", scurve_test_top_inst.count_ack, 0, errs);
      check_value("result_req", scurve_test_top_inst.result_req, 0, errs);
    end
    check_value("FIFO word count", got_q.size(), 0, errs);
    report_test("idle after reset", errs);
  endtask

  task automatic single_channel_ctest();
    scurve_cfg_t c;
    int          errs;
    errs         = 0;
    c            = '0;
    c.single_chn = 6'd16;
    c.ctest_mode = 1'b1;
    c.cpt_max    = 16'd4;
    c.dac_start  = 10'd3;
    c.dac_stop   = 10'd8;
    scan_and_check(c, 64'd1 << 16, 1'b0, errs);
    check_value("words in single channel sweep", got_q.size(), 24, errs);
    report_test("single channel ctest sweep", errs);
  endtask

  task automatic input_mode_sweep();
    scurve_cfg_t c;
    int          errs;
    errs         = 0;
    c            = '0;
    c.single_chn = 6'd16;
    c.cpt_max    = 16'd7;
    c.dac_start  = 10'd3;
    c.dac_stop   = 10'd8;
    scan_and_check(c, 64'd0, 1'b0, errs);
    report_test("external input sweep", errs);
  endtask

  task automatic all_channel_sweep();
    scurve_cfg_t c;
    int          errs;
    errs        = 0;
    c           = '0;
    c.all_chn   = 1'b1;
    c.cpt_max   = 16'd1;
    c.dac_start = 10'd0;
    c.dac_stop  = 10'd1;
    scan_and_check(c, 64'd0, 1'b0, errs);
    check_value("groups in all channel sweep", got_q.size() / 4, `NUM_CHN * 2, errs);
    report_test("all channel sweep", errs);
  endtask

  // Sweep reaches code 9 so that trigger 2 also counts
  task automatic fifo_back_pressure();
    scurve_cfg_t c;
    int          errs;
    errs         = 0;
    c            = '0;
    c.single_chn = 6'd40;
    c.ctest_mode = 1'b1;
    c.cpt_max    = 16'd2;
    c.dac_start  = 10'd2;
    c.dac_stop   = 10'd9;
    scan_and_check(c, 64'd1 << 40, 1'b1, errs);
    report_test("FIFO back-pressure", errs);
  endtask

  initial begin
    reset_n      = 1'b0;
    start        = 1'b0;
    cfg          = '0;
    exp_mask     = '0;
    threshold[0] = 10'd0;
    threshold[1] = 10'd5;
    threshold[2] = 10'd9;
    tests_run    = 0;
    tests_passed = 0;
    tests_failed = 0;
    idle_after_reset();
    single_channel_ctest();
    input_mode_sweep();
    all_channel_sweep();
    fifo_back_pressure();
    $display("tests run %0d, passed %0d, failed %0d", tests_run, tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* testbench/asic_model.sv */
`default_nettype none

`include "scurve_consts.svh"

module asic_model (
  input  wire logic                               clk_n,
  input  wire logic                               reset_n,
  input  wire logic                               sc_param_load,
  input  wire logic [`DAC_W-1:0]                  dac_code,
  input  wire logic [`NUM_TRIG-1:0][`DAC_W-1:0]   threshold,
  output logic                                    config_done,
  output logic                                    clk_ext,
  output logic                                    trigger0_b,
  output logic                                    trigger1_b,
  output logic                                    trigger2_b
);

  logic [3:0]           phase_cnt;
  logic [2:0]           load_cnt;
  logic [`NUM_TRIG-1:0] trig_b;

  assign trigger0_b = trig_b[0];
  assign trigger1_b = trig_b[1];
  assign trigger2_b = trig_b[2];

  always @(negedge clk_n or negedge reset_n) begin
    if (!reset_n) begin
      phase_cnt   <= '0;
      load_cnt    <= '0;
      config_done <= 1'b0;
      clk_ext     <= 1'b0;
      trig_b      <= '1;
    end else begin
      // clk_ext half period is 10 clk_n cycles
      if (phase_cnt == 4'd9) begin
        phase_cnt <= '0;
        clk_ext   <= !clk_ext;
      end else begin
        phase_cnt <= phase_cnt + 1'b1;
      end
      // Slow control takes a few cycles to report done
      if (sc_param_load && !config_done) begin
        if (load_cnt == 3'd3) begin
          config_done <= 1'b1;
        end else begin
          load_cnt <= load_cnt + 1'b1;
        end
      end else if (!sc_param_load) begin
        config_done <= 1'b0;
        load_cnt    <= '0;
      end
      // Two cycle low pulse mid high phase while at or above threshold
      for (int k = 0; k < `NUM_TRIG; k++) begin
        trig_b[k] <= !(clk_ext && (phase_cnt == 4'd4 || phase_cnt == 4'd5) &&
                       dac_code >= threshold[k]);
      end
    end
  end

endmodule

`default_nettype wire

/* logic/scurve_test_top.sv */
`default_nettype none

`include "scurve_consts.svh"

module scurve_test_top
  import scurve_pkg::*;
(
  input  wire logic                clk_n,
  input  wire logic                reset_n,
  // Host
  input  wire scurve_cfg_t         cfg,
  input  wire logic                start,
  output logic                     scan_done,
  // USB data FIFO
  output logic                     fifo_wr_en,
  output logic [`WORD_W-1:0]       fifo_din,
  input  wire logic                fifo_full,
  // ASIC slow control
  output logic [`NUM_CHN-1:0]      ctest_mask,
  output logic [`DAC_W-1:0]        dac_code,
  output logic                     sc_param_load,
  input  wire logic                config_done,
  // Asynchronous pins
  input  wire logic                clk_ext,
  input  wire logic                trigger0_b,
  input  wire logic                trigger1_b,
  input  wire logic                trigger2_b
);

  logic         count_req;
  logic         count_ack;
  trig_count_t  trig_count;
  logic         result_req;
  logic         result_ack;
  step_result_t result;

  scurve_sequencer scurve_sequencer_inst (
    .clk_n         (clk_n),
    .reset_n       (reset_n),
    .start         (start),
    .cfg           (cfg),
    .sc_param_load (sc_param_load),
    .config_done   (config_done),
    .dac_code      (dac_code),
    .ctest_mask    (ctest_mask),
    .count_req     (count_req),
    .count_ack     (count_ack),
    .trig_count    (trig_count),
    .result_req    (result_req),
    .result_ack    (result_ack),
    .result        (result),
    .scan_done     (scan_done)
  );

  // Window length comes straight from the host setup
  trigger_counter trigger_counter_inst (
    .clk_n      (clk_n),
    .reset_n    (reset_n),
    .clk_ext    (clk_ext),
    .trigger0_b (trigger0_b),
    .trigger1_b (trigger1_b),
    .trigger2_b (trigger2_b),
    .cpt_max    (cfg.cpt_max),
    .count_req  (count_req),
    .count_ack  (count_ack),
    .trig_count (trig_count)
  );

  result_packer result_packer_inst (
    .clk_n      (clk_n),
    .reset_n    (reset_n),
    .result_req (result_req),
    .result_ack (result_ack),
    .result     (result),
    .fifo_wr_en (fifo_wr_en),
    .fifo_din   (fifo_din),
    .fifo_full  (fifo_full)
  );

endmodule

`default_nettype wire

/* logic/result_packer.sv */
`default_nettype none

`include "scurve_consts.svh"

module result_packer
  import scurve_pkg::*;
(
  input  wire logic                clk_n,
  input  wire logic                reset_n,
  input  wire logic                result_req,
  output logic                     result_ack,
  input  wire step_result_t        result,
  output logic                     fifo_wr_en,
  output logic [`WORD_W-1:0]       fifo_din,
  input  wire logic                fifo_full
);

  localparam logic [1:0] LAST_WORD = 2'd3;

  typedef enum logic [1:0] {
    S_IDLE,
    S_WRITE,
    S_ACK
  } state_t;

  state_t       state;
  logic [1:0]   word_idx;
  step_result_t res_q;
  scurve_word_u word;
  logic         take;

  assign take = (state == S_IDLE) && result_req;

  // Header first and then triggers 0, 1 and 2
  always_comb begin
    word = '0;
    if (word_idx == 2'd0) begin
      word.hdr.dac_code = res_q.dac_code;
      word.hdr.channel  = res_q.channel;
    end else begin
      word.cnt.count = res_q.trig_count[word_idx - 2'd1];
    end
  end

  assign fifo_din = word;
  // The word just waits while the FIFO is full
  assign fifo_wr_en = (state == S_WRITE) && !fifo_full;

  always_ff @(posedge clk_n or negedge reset_n) begin
    if (!reset_n) begin
      state      <= S_IDLE;
      word_idx   <= '0;
      result_ack <= 1'b0;
    end else begin
      case (state)
        S_IDLE: begin
          if (take) begin
            word_idx <= '0;
            state    <= S_WRITE;
          end
        end
        S_WRITE: begin
          if (fifo_wr_en) begin
            if (word_idx == LAST_WORD) begin
              result_ack <= 1'b1;
              state      <= S_ACK;
            end else begin
              word_idx <= word_idx + 1'b1;
            end
          end
        end
        S_ACK: begin
          if (!result_req) begin
            result_ack <= 1'b0;
            state      <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // Local copy frees the sequencer to build the next result
  always_ff @(posedge clk_n) begin
    if (take) begin
      res_q <= result;
    end
  end

  // A word held back by a full FIFO is offered again unchanged
  a_hold_while_full: assert property (@(posedge clk_n) disable iff (!reset_n)
    (state == S_WRITE) && fifo_full |=> (state == S_WRITE) && $stable(fifo_din));

endmodule

`default_nettype wire

/* logic/trigger_counter.sv */
`default_nettype none

`include "scurve_consts.svh"

module trigger_counter
  import scurve_pkg::*;
(
  input  wire logic               clk_n,
  input  wire logic               reset_n,
  input  wire logic               clk_ext,
  input  wire logic               trigger0_b,
  input  wire logic               trigger1_b,
  input  wire logic               trigger2_b,
  input  wire logic [`WORD_W-1:0] cpt_max,
  input  wire logic               count_req,
  output logic                    count_ack,
  output trig_count_t             trig_count
);

  localparam int NPIN = `NUM_TRIG + 1;
  // clk_ext idles low and the triggers idle high
  localparam logic [NPIN-1:0] PIN_IDLE = {{`NUM_TRIG{1'b1}}, 1'b0};

  typedef enum logic [1:0] {
    S_IDLE,
    S_ARM,
    S_OPEN,
    S_DONE
  } state_t;

  state_t                              state;
  logic [`SYNC_STAGES-1:0][NPIN-1:0]   sync_q;
  logic [NPIN-1:0]                     pins;
  logic [NPIN-1:0]                     pin_s;
  logic [NPIN-1:0]                     pin_q;
  logic                                ext_rise;
  logic [`NUM_TRIG-1:0]                trig_fall;
  logic [`WORD_W-1:0]                  per_cnt;
  logic                                window_open;

  // Bit 0 is clk_ext and bit k+1 is trigger k
  assign pins  = {trigger2_b, trigger1_b, trigger0_b, clk_ext};
  assign pin_s = sync_q[`SYNC_STAGES-1];

  assign ext_rise    = pin_s[0] && !pin_q[0];
  assign trig_fall   = pin_q[NPIN-1:1] & ~pin_s[NPIN-1:1];
  assign window_open = (state == S_OPEN);

  always_ff @(posedge clk_n or negedge reset_n) begin
    if (!reset_n) begin
      sync_q <= {`SYNC_STAGES{PIN_IDLE}};
      pin_q  <= PIN_IDLE;
    end else begin
      sync_q <= {sync_q[`SYNC_STAGES-2:0], pins};
      pin_q  <= pin_s;
    end
  end

  always_ff @(posedge clk_n or negedge reset_n) begin
    if (!reset_n) begin
      state      <= S_IDLE;
      per_cnt    <= '0;
      count_ack  <= 1'b0;
      trig_count <= '0;
    end else begin
      // Saturating so that a noisy trigger cannot wrap a count
      for (int k = 0; k < `NUM_TRIG; k++) begin
        if (window_open && trig_fall[k] && trig_count[k] != '1) begin
          trig_count[k] <= trig_count[k] + 1'b1;
        end
      end
      case (state)
        S_IDLE: begin
          if (count_req) begin
            trig_count <= '0;
            state      <= S_ARM;
          end
        end
        S_ARM: begin
          if (ext_rise) begin
            per_cnt <= '0;
            if (cpt_max == '0) begin
              count_ack <= 1'b1;
              state     <= S_DONE;
            end else begin
              state <= S_OPEN;
            end
          end
        end
        S_OPEN: begin
          // Rising edge cpt_max + 1 closes the window
          if (ext_rise) begin
            if (per_cnt == cpt_max - 1'b1) begin
              count_ack <= 1'b1;
              state     <= S_DONE;
            end else begin
              per_cnt <= per_cnt + 1'b1;
            end
          end
        end
        S_DONE: begin
          if (!count_req) begin
            count_ack <= 1'b0;
            state     <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  for (genvar k = 0; k < `NUM_TRIG; k++) begin : g_bound
    a_count_bound: assert property (@(posedge clk_n) disable iff (!reset_n)
      (state == S_OPEN || state == S_DONE) |->
        ({1'b0, trig_count[k]} <= {1'b0, cpt_max} + 1'b1));
  end

endmodule

`default_nettype wire

/* logic/scurve_sequencer.sv */
`default_nettype none

`include "scurve_consts.svh"

module scurve_sequencer
  import scurve_pkg::*;
(
  input  wire logic                clk_n,
  input  wire logic                reset_n,
  input  wire logic                start,
  input  wire scurve_cfg_t         cfg,
  output logic                     sc_param_load,
  input  wire logic                config_done,
  output logic [`DAC_W-1:0]        dac_code,
  output logic [`NUM_CHN-1:0]      ctest_mask,
  output logic                     count_req,
  input  wire logic                count_ack,
  input  wire trig_count_t         trig_count,
  output logic                     result_req,
  input  wire logic                result_ack,
  output step_result_t             result,
  output logic                     scan_done
);

  localparam logic [`CHN_W-1:0]   LAST_CHN  = `CHN_W'(`NUM_CHN - 1);
  localparam logic [`NUM_CHN-1:0] MASK_BIT0 = `NUM_CHN'(1);

  typedef enum logic [2:0] {
    S_IDLE,
    S_SETUP,
    S_LOAD,
    S_UNLOAD,
    S_COUNT,
    S_HAND,
    S_NEXT,
    S_FLUSH
  } state_t;

  state_t            state;
  logic              start_q;
  logic              all_chn_q;
  logic              ctest_q;
  logic [`DAC_W-1:0] dac_start_q;
  logic [`DAC_W-1:0] dac_stop_q;
  logic [`CHN_W-1:0] chn_q;
  logic [`DAC_W-1:0] code_q;
  trig_count_t       cnt_q;
  logic              take_counts;
  logic              hand_over;

  // Previous result transfer must be fully closed before a new one
  assign take_counts = (state == S_COUNT) && count_ack;
  assign hand_over   = (state == S_HAND) && !result_req && !result_ack;

  always_ff @(posedge clk_n or negedge reset_n) begin
    if (!reset_n) begin
      state         <= S_IDLE;
      start_q       <= 1'b0;
      all_chn_q     <= 1'b0;
      ctest_q       <= 1'b0;
      dac_start_q   <= '0;
      dac_stop_q    <= '0;
      chn_q         <= '0;
      code_q        <= '0;
      sc_param_load <= 1'b0;
      dac_code      <= '0;
      ctest_mask    <= '0;
      count_req     <= 1'b0;
      result_req    <= 1'b0;
      scan_done     <= 1'b0;
    end else begin
      start_q   <= start;
      scan_done <= 1'b0;
      // Result transfer runs on its own while the next step proceeds
      if (result_req && result_ack) begin
        result_req <= 1'b0;
      end
      case (state)
        S_IDLE: begin
          if (start && !start_q) begin
            all_chn_q   <= cfg.all_chn;
            ctest_q     <= cfg.ctest_mode;
            dac_start_q <= cfg.dac_start;
            dac_stop_q  <= cfg.dac_stop;
            chn_q       <= cfg.all_chn ? '0 : cfg.single_chn;
            code_q      <= cfg.dac_start;
            state       <= S_SETUP;
          end
        end
        S_SETUP: begin
          dac_code      <= code_q;
          ctest_mask    <= ctest_q ? (MASK_BIT0 << chn_q) : '0;
          sc_param_load <= 1'b1;
          state         <= S_LOAD;
        end
        S_LOAD: begin
          if (config_done) begin
            sc_param_load <= 1'b0;
            state         <= S_UNLOAD;
          end
        end
        S_UNLOAD: begin
          // Also wait until the counter has closed the last request
          if (!config_done && !count_ack) begin
            count_req <= 1'b1;
            state     <= S_COUNT;
          end
        end
        S_COUNT: begin
          if (take_counts) begin
            count_req <= 1'b0;
            state     <= S_HAND;
          end
        end
        S_HAND: begin
          if (hand_over) begin
            result_req <= 1'b1;
            state      <= S_NEXT;
          end
        end
        S_NEXT: begin
          if (code_q != dac_stop_q) begin
            code_q <= code_q + 1'b1;
            state  <= S_SETUP;
          end else if (all_chn_q && chn_q != LAST_CHN) begin
            chn_q  <= chn_q + 1'b1;
            code_q <= dac_start_q;
            state  <= S_SETUP;
          end else begin
            state <= S_FLUSH;
          end
        end
        S_FLUSH: begin
          // Done once the packer has taken the last step
          if (!result_req && !result_ack) begin
            scan_done <= 1'b1;
            state     <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_n) begin
    if (take_counts) begin
      cnt_q <= trig_count;
    end
    if (hand_over) begin
      result.channel    <= chn_q;
      result.dac_code   <= code_q;
      result.trig_count <= cnt_q;
    end
  end

  // The ASIC side must see the load until it reports done
  a_load_held: assert property (@(posedge clk_n) disable iff (!reset_n)
    sc_param_load && !config_done |=> sc_param_load);

  a_result_stable: assert property (@(posedge clk_n) disable iff (!reset_n)
    result_req |=> !result_req || $stable(result));

endmodule

`default_nettype wire

/* logic/scurve_pkg.sv */
`default_nettype none

`include "scurve_consts.svh"

package scurve_pkg;

  // Count k belongs to trigger output k
  typedef logic [`NUM_TRIG-1:0][`WORD_W-1:0] trig_count_t;

  // Test setup from the host
  typedef struct packed {
    logic [`CHN_W-1:0]  single_chn;
    logic               all_chn;     // sweep channels 0 to 63
    logic               ctest_mode;  // high for charge injection
    logic [`WORD_W-1:0] cpt_max;     // clk_ext periods per window
    logic [`DAC_W-1:0]  dac_start;
    logic [`DAC_W-1:0]  dac_stop;
  } scurve_cfg_t;

  // Outcome of one DAC step
  typedef struct packed {
    logic [`CHN_W-1:0] channel;
    logic [`DAC_W-1:0] dac_code;
    trig_count_t       trig_count;
  } step_result_t;

  // Word 0 of a group
  typedef struct packed {
    logic [`DAC_W-1:0] dac_code;
    logic [`CHN_W-1:0] channel;
  } hdr_word_t;

  // Words 1 to 3 of a group
  typedef struct packed {
    logic [`WORD_W-1:0] count;
  } cnt_word_t;

  // Position in the group of four selects the view
  typedef union packed {
    hdr_word_t hdr;
    cnt_word_t cnt;
  } scurve_word_u;

endpackage

`default_nettype wire

/* logic/scurve_consts.svh */
`ifndef SCURVE_CONSTS_SVH
`define SCURVE_CONSTS_SVH

// Channels on the front-end ASIC
`define NUM_CHN 64

// Width of a channel number
`define CHN_W 6

// Threshold DAC code width
`define DAC_W 10

// Width of a USB data FIFO word and of every trigger count
`define WORD_W 16

// Flops between an asynchronous pin and its edge detector
`define SYNC_STAGES 2

// Trigger outputs per channel (trigger0_b to trigger2_b)
`define NUM_TRIG 3

`endif
